//--- cache_pkg.sv
package cache_pkg;

	//////////////////////////////
	// Geometry
	//////////////////////////////
	localparam int WORDS_PER_LINE = 4;
	localparam int INDEX_W = 3;
	localparam int TAG_W = 25;
	localparam int OFFSET_W = $clog2(WORDS_PER_LINE);

	typedef logic [31:0] word_t;

	// Word 0 sits in the low bits
	typedef word_t [WORDS_PER_LINE-1:0] line_t;

	typedef logic [TAG_W+INDEX_W-1:0] block_addr_t;

	// Same word address, seen by the lookup or by memory
	typedef union packed {
		struct packed {
			logic [TAG_W-1:0]    tag;
			logic [INDEX_W-1:0]  index;
			logic [OFFSET_W-1:0] word;
		} lookup;
		struct packed {
			block_addr_t         block;
			logic [OFFSET_W-1:0] word;
		} mem;
	} word_addr_u;

	//////////////////////////////
	// Port bundles
	//////////////////////////////
	typedef struct packed {
		logic       read;
		logic       write;
		word_addr_u addr;
		word_t      wdata;
	} cache_req_t;

	typedef struct packed {
		word_t rdata;
		logic  stall;
	} cache_rsp_t;

	// Four-phase req/ack toward memory
	typedef struct packed {
		logic        req;
		logic        write;
		block_addr_t block;
		line_t       wdata;
	} mem_req_t;

	typedef struct packed {
		logic  ack;
		line_t rdata;
	} mem_rsp_t;

	typedef enum logic [2:0] {
		IDLE,
		WB_REQ,
		WB_RELEASE,
		FILL_REQ,
		FILL_RELEASE
	} ctrl_state_e;

endpackage

//--- cache_lines.sv
`timescale 1ns/1ps

module cache_lines
	import cache_pkg::*;
(
	input  logic        clk,
	input  logic        rst_n,
	input  word_addr_u  addr,
	input  logic        wr_word,
	input  word_t       wdata,
	input  logic        fill,
	input  line_t       fill_data,
	output logic        hit,
	output logic        dirty,
	output word_t       rdata,
	output block_addr_t victim_block,
	output line_t       victim_data
);

	localparam int LINES = 1 << INDEX_W;

	line_t              data_mem [0:LINES-1];
	logic [TAG_W-1:0]   tag_mem  [0:LINES-1];
	logic [LINES-1:0]   valid_q;
	logic [LINES-1:0]   dirty_q;
	logic [INDEX_W-1:0] idx;
	word_addr_u         victim_addr;

	assign idx = addr.lookup.index;

	//////////////////////////////
	// Lookup
	//////////////////////////////
	assign hit = valid_q[idx] && (tag_mem[idx] == addr.lookup.tag);
	assign dirty = dirty_q[idx];
	assign rdata = data_mem[idx][addr.lookup.word];

	// Rebuild the resident line's block address from its stored tag
	always_comb begin
		victim_addr = '0;
		victim_addr.lookup.tag = tag_mem[idx];
		victim_addr.lookup.index = idx;
	end

	assign victim_block = victim_addr.mem.block;
	assign victim_data = data_mem[idx];

	//////////////////////////////
	// Update
	//////////////////////////////
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			valid_q <= '0;
			dirty_q <= '0;
		end else if (fill) begin
			valid_q[idx] <= 1'b1;
			dirty_q[idx] <= 1'b0;
		end else if (wr_word) begin
			dirty_q[idx] <= 1'b1;
		end
	end

	always_ff @(posedge clk) begin
		if (fill) begin
			data_mem[idx] <= fill_data;
			tag_mem[idx] <= addr.lookup.tag;
		end else if (wr_word) begin
			data_mem[idx][addr.lookup.word] <= wdata;
		end
	end

	// Controller never refills and writes a word in the same cycle
	assert property (@(posedge clk) disable iff (!rst_n) !(fill && wr_word))
		else $error("cache_lines: fill and wr_word together");

endmodule

//--- cache_ctrl.sv
`timescale 1ns/1ps

module cache_ctrl
	import cache_pkg::*;
(
	input  logic       clk,
	input  logic       rst_n,
	input  cache_req_t cpu_req,
	output cache_rsp_t cpu_rsp,
	output mem_req_t   mem_req,
	input  mem_rsp_t   mem_rsp
);

	ctrl_state_e state;
	ctrl_state_e state_next;
	logic        live;
	logic        hit;
	logic        dirty;
	logic        wr_word;
	logic        fill;
	word_t       rdata;
	block_addr_t victim_block;
	line_t       victim_data;

	assign live = cpu_req.read || cpu_req.write;

	// Write hits land at the edge that ends the access
	assign wr_word = (state == IDLE) && cpu_req.write && hit;
	assign fill = (state == FILL_REQ) && mem_rsp.ack;

	cache_lines u_lines (
		.clk          (clk),
		.rst_n        (rst_n),
		.addr         (cpu_req.addr),
		.wr_word      (wr_word),
		.wdata        (cpu_req.wdata),
		.fill         (fill),
		.fill_data    (mem_rsp.rdata),
		.hit          (hit),
		.dirty        (dirty),
		.rdata        (rdata),
		.victim_block (victim_block),
		.victim_data  (victim_data)
	);

	//////////////////////////////
	// Miss FSM
	//////////////////////////////
	always_comb begin
		state_next = state;
		case (state)
			IDLE: begin
				if (live && !hit)
					state_next = dirty ? WB_REQ : FILL_REQ;
			end
			WB_REQ: begin
				if (mem_rsp.ack)
					state_next = WB_RELEASE;
			end
			// Wait for ack to drop before the fill req
			WB_RELEASE: begin
				if (!mem_rsp.ack)
					state_next = FILL_REQ;
			end
			FILL_REQ: begin
				if (mem_rsp.ack)
					state_next = FILL_RELEASE;
			end
			FILL_RELEASE: begin
				if (!mem_rsp.ack)
					state_next = IDLE;
			end
			default: state_next = IDLE;
		endcase
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n)
			state <= IDLE;
		else
			state <= state_next;
	end

	//////////////////////////////
	// Memory requester
	//////////////////////////////
	always_comb begin
		mem_req.req = (state == WB_REQ) || (state == FILL_REQ);
		mem_req.write = (state == WB_REQ);
		mem_req.wdata = victim_data;
		if (state == WB_REQ)
			mem_req.block = victim_block;
		else
			mem_req.block = cpu_req.addr.mem.block;
	end

	// Retried access hits once the FSM is back in IDLE
	assign cpu_rsp.rdata = rdata;
	assign cpu_rsp.stall = (state != IDLE) || (live && !hit);

	// Four-phase rule on the requester side
	assert property (@(posedge clk) disable iff (!rst_n)
		mem_req.req && !mem_rsp.ack |=> mem_req.req)
		else $error("cache_ctrl: req dropped before ack");

endmodule

//--- mem_arbiter.sv
`timescale 1ns/1ps

module mem_arbiter
	import cache_pkg::*;
(
	input  logic     clk,
	input  logic     rst_n,
	input  mem_req_t port0_req,
	input  mem_req_t port1_req,
	output mem_rsp_t port0_rsp,
	output mem_rsp_t port1_rsp,
	output mem_req_t mem_req,
	input  mem_rsp_t mem_rsp
);

	// One-hot grant, all zero while idle
	logic [1:0] grant;
	logic       last;
	logic       pick;
	mem_req_t   sel_req;

	// Alternate on a tie, otherwise take whoever asks
	always_comb begin
		if (port0_req.req && port1_req.req)
			pick = ~last;
		else
			pick = port1_req.req;
	end

	assign sel_req = grant[1] ? port1_req : port0_req;

	//////////////////////////////
	// Grant tracking
	//////////////////////////////
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			grant <= 2'b00;
			last <= 1'b1;
		end else if (grant == 2'b00) begin
			if (port0_req.req || port1_req.req) begin
				grant <= pick ? 2'b10 : 2'b01;
				last <= pick;
			end
		end else if (!sel_req.req && !mem_rsp.ack) begin
			// Return to zero complete on both sides
			grant <= 2'b00;
		end
	end

	always_comb begin
		mem_req = sel_req;
		mem_req.req = sel_req.req && (grant != 2'b00);
	end

	assign port0_rsp.rdata = mem_rsp.rdata;
	assign port0_rsp.ack = grant[0] && mem_rsp.ack;
	assign port1_rsp.rdata = mem_rsp.rdata;
	assign port1_rsp.ack = grant[1] && mem_rsp.ack;

	assert property (@(posedge clk) disable iff (!rst_n)
		!(port0_rsp.ack && port1_rsp.ack))
		else $error("mem_arbiter: ack routed to both ports");

endmodule

//--- cache_subsystem.sv
`timescale 1ns/1ps

module cache_subsystem
	import cache_pkg::*;
(
	input  logic       clk,
	input  logic       rst_n,
	input  cache_req_t port0_req,
	input  cache_req_t port1_req,
	output cache_rsp_t port0_rsp,
	output cache_rsp_t port1_rsp,
	output mem_req_t   mem_req,
	input  mem_rsp_t   mem_rsp
);

	mem_req_t cache0_mem_req;
	mem_req_t cache1_mem_req;
	mem_rsp_t cache0_mem_rsp;
	mem_rsp_t cache1_mem_rsp;

	// Port 0 and port 1 must stay in disjoint regions
	cache_ctrl u_cache0 (
		.clk     (clk),
		.rst_n   (rst_n),
		.cpu_req (port0_req),
		.cpu_rsp (port0_rsp),
		.mem_req (cache0_mem_req),
		.mem_rsp (cache0_mem_rsp)
	);

	cache_ctrl u_cache1 (
		.clk     (clk),
		.rst_n   (rst_n),
		.cpu_req (port1_req),
		.cpu_rsp (port1_rsp),
		.mem_req (cache1_mem_req),
		.mem_rsp (cache1_mem_rsp)
	);

	mem_arbiter u_arbiter (
		.clk       (clk),
		.rst_n     (rst_n),
		.port0_req (cache0_mem_req),
		.port1_req (cache1_mem_req),
		.port0_rsp (cache0_mem_rsp),
		.port1_rsp (cache1_mem_rsp),
		.mem_req   (mem_req),
		.mem_rsp   (mem_rsp)
	);

endmodule

//--- tb_mem_model.sv
`timescale 1ns/1ps

module tb_mem_model
	import cache_pkg::*;
(
	input  logic     clk,
	input  logic     rst_n,
	input  mem_req_t mem_req,
	output mem_rsp_t mem_rsp
);

	logic [15:0] lfsr;
	block_addr_t stored_block [$];
	line_t       stored_line  [$];

	// Fibonacci taps x^16 + x^14 + x^13 + x^11 + 1
	function automatic logic [15:0] lfsr_step(input logic [15:0] s);
		return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
	endfunction

	// One step per delay bit
	task automatic pick_delay(output int cycles);
		logic [1:0] bits;
		for (int i = 0; i < 2; i++) begin
			lfsr = lfsr_step(lfsr);
			bits[i] = lfsr[0];
		end
		cycles = bits;
	endtask

	// Unwritten words hold their word address XOR C0DE0000
	function automatic line_t read_line(input block_addr_t blk);
		line_t      ln;
		word_addr_u a;
		for (int w = 0; w < WORDS_PER_LINE; w++) begin
			a.mem.block = blk;
			a.mem.word = OFFSET_W'(w);
			ln[w] = {2'b00, a} ^ 32'hC0DE0000;
		end
		// Latest write-back of this block wins
		for (int k = stored_block.size() - 1; k >= 0; k--) begin
			if (stored_block[k] == blk)
				return stored_line[k];
		end
		return ln;
	endfunction

	//////////////////////////////
	// Four-phase responder
	//////////////////////////////
	initial begin : serve
		int          d;
		block_addr_t blk;
		logic        wr;
		line_t       wd;
		lfsr = 16'd939;
		mem_rsp = '0;
		forever begin
			@(negedge clk);
			if (rst_n && mem_req.req) begin
				blk = mem_req.block;
				wr = mem_req.write;
				wd = mem_req.wdata;
				pick_delay(d);
				repeat (d) @(posedge clk);
				@(posedge clk);
				if (wr) begin
					stored_block.push_back(blk);
					stored_line.push_back(wd);
					mem_rsp <= '{ack: 1'b1, rdata: '0};
				end else begin
					mem_rsp <= '{ack: 1'b1, rdata: read_line(blk)};
				end
				// Hold ack until req drops
				do
					@(negedge clk);
				while (mem_req.req);
				pick_delay(d);
				repeat (d) @(posedge clk);
				@(posedge clk);
				mem_rsp.ack <= 1'b0;
			end
		end
	end

endmodule

//--- tb_cache_subsystem.sv
`timescale 1ns/1ps

module tb_cache_subsystem
	import cache_pkg::*;
();

	typedef struct packed {
		logic       port;
		logic       write;
		word_addr_u addr;
		word_t      data;
	} test_row_t;

	localparam int CYCLES_PER_ROW = 60;
	localparam int CLK_PERIOD = 4;

	logic       clk;
	logic       rst_n;
	cache_req_t port0_req;
	cache_req_t port1_req;
	cache_rsp_t port0_rsp;
	cache_rsp_t port1_rsp;
	mem_req_t   mem_req;
	mem_rsp_t   mem_rsp;
	test_row_t  rows [$];
	int         row_count;

	cache_subsystem u_cache_subsystem (
		.clk       (clk),
		.rst_n     (rst_n),
		.port0_req (port0_req),
		.port1_req (port1_req),
		.port0_rsp (port0_rsp),
		.port1_rsp (port1_rsp),
		.mem_req   (mem_req),
		.mem_rsp   (mem_rsp)
	);

	tb_mem_model u_mem (
		.clk     (clk),
		.rst_n   (rst_n),
		.mem_req (mem_req),
		.mem_rsp (mem_rsp)
	);

	always #2 clk = ~clk;

	//////////////////////////////
	// Compare tasks
	//////////////////////////////
	task automatic check_word(input string name, input word_t got, input word_t exp);
		if (got !== exp) begin
			$display("FAILED at %0t: %s got %h expected %h", $time, name, got, exp);
			$display("TESTBENCH FAILED");
			$fatal(1, "read data mismatch");
		end
	endtask

	task automatic check_flag(input string name, input logic got, input logic exp);
		if (got !== exp) begin
			$display("FAILED at %0t: %s got %b expected %b", $time, name, got, exp);
			$display("TESTBENCH FAILED");
			$fatal(1, "flag mismatch");
		end
	endtask

	// Rows are: port, op, word address, data
	task automatic load_rows();
		int              fd;
		int              n;
		int              port;
		byte             op;
		logic [31:0]     addr;
		word_t           data;
		logic [8*96-1:0] text;
		test_row_t       row;
		fd = $fopen("cache_tests.txt", "r");
		if (fd == 0) begin
			$display("Could not open cache_tests.txt for reading");
			$display("TESTBENCH FAILED");
			$fatal(1, "missing test data");
		end
		while (!$feof(fd)) begin
			text = '0;
			n = $fgets(text, fd);
			if (n > 0 && $sscanf(text, "%d %c %h %h", port, op, addr, data) == 4) begin
				row.port = port[0];
				row.write = (op == "W");
				row.addr = addr[29:0];
				row.data = data;
				rows.push_back(row);
			end
		end
		$fclose(fd);
		row_count = rows.size();
	endtask

	task automatic drive_port(input int p, input cache_req_t r);
		if (p == 0)
			port0_req <= r;
		else
			port1_req <= r;
	endtask

	// Each port walks its own rows; both run side by side
	task automatic run_port(input int p);
		cache_req_t r;
		cache_rsp_t rsp;
		string      name;
		for (int i = 0; i < rows.size(); i++) begin
			if (rows[i].port == p[0]) begin
				r.read = !rows[i].write;
				r.write = rows[i].write;
				r.addr = rows[i].addr;
				r.wdata = rows[i].write ? rows[i].data : '0;
				@(posedge clk);
				drive_port(p, r);
				do begin
					@(negedge clk);
					rsp = (p == 0) ? port0_rsp : port1_rsp;
				end while (rsp.stall);
				if (!rows[i].write) begin
					name = $sformatf("port%0d_rsp.rdata (addr %h)", p, rows[i].addr);
					check_word(name, rsp.rdata, rows[i].data);
				end
			end
		end
		@(posedge clk);
		drive_port(p, '0);
	endtask

	//////////////////////////////
	// Main sequence
	//////////////////////////////
	initial begin : main
		$timeformat(-9, 0, " ns", 0);
		clk = 1'b0;
		rst_n = 1'b0;
		port0_req = '0;
		port1_req = '0;
		load_rows();
		if (row_count == 0) begin
			$display("No test rows were found in cache_tests.txt");
			$display("TESTBENCH FAILED");
			$fatal(1, "empty test data");
		end
		repeat (5) @(posedge clk);
		rst_n <= 1'b1;
		// Idle state right after reset
		@(negedge clk);
		check_flag("port0_rsp.stall", port0_rsp.stall, 1'b0);
		check_flag("port1_rsp.stall", port1_rsp.stall, 1'b0);
		check_flag("mem_req.req", mem_req.req, 1'b0);
		fork
			run_port(0);
			run_port(1);
		join
		repeat (2) @(posedge clk);
		$display("TESTBENCH PASSED");
		$finish;
	end

	initial begin : watchdog
		wait (row_count > 0);
		#(row_count * CYCLES_PER_ROW * CLK_PERIOD);
		$display("Timeout: the run did not finish within %0d cycles",
			row_count * CYCLES_PER_ROW);
		$display("TESTBENCH FAILED");
		$fatal(1, "watchdog expired");
	end

endmodule

//--- cache_tests.txt
# port op(R/W) word_addr(hex) data(hex)
# R rows carry the expected read value, W rows the value written
0 R 00000010 C0DE0010
1 R 20000010 E0DE0010
0 R 00000011 C0DE0011
1 W 20000011 12345678
0 R 00000013 C0DE0013
1 R 20000011 12345678
0 W 00000012 11112222
1 R 20000050 E0DE0050
0 R 00000012 11112222
1 R 20000052 E0DE0052
0 W 00000024 AAAA0001
1 R 20000011 12345678
0 R 00000024 AAAA0001
1 W 30000008 DEADBEEF
0 R 00000025 C0DE0025
1 R 30000009 F0DE0009
0 R 00000044 C0DE0044
1 R 30000008 DEADBEEF
0 R 00000024 AAAA0001
1 R 3FFFFFFF FF21FFFF
0 R 00000025 C0DE0025
1 R 3FFFFFFC FF21FFFC
0 W 00000031 5555AAAA
1 R 30000028 F0DE0028
0 R 00000012 11112222
1 R 30000008 DEADBEEF
0 R 00000031 5555AAAA
0 R 00000010 C0DE0010
0 R 00000013 C0DE0013
0 R 0FFFFFF8 CF21FFF8

//--- flist.f
cache_pkg.sv
cache_lines.sv
cache_ctrl.sv
mem_arbiter.sv
cache_subsystem.sv
tb_mem_model.sv
tb_cache_subsystem.sv
